//--- build.f
logic/cpu_pkg.sv
logic/vector_loader.sv
logic/fetch_control.sv
logic/inst_decode.sv
logic/alu8.sv
logic/reg_file.sv
logic/cpu_core.sv
testbench/cpu_core_chk.sv
testbench/tb_cpu_core.sv

//--- logic/alu8.sv
/*
  8-bit ALU
  Arithmetic, logic, shift and rotate on A or B with 6809 N, Z, V, C
  and H results
*/
`timescale 1ns/1ps

module alu8 import cpu_pkg::*; (
  input  alu_op_e           op,
  input  logic              acc_b,
  input  logic              use_imm,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  logic [DATA_W-1:0] imm,
  input  logic [7:0]        cc,
  output logic [DATA_W-1:0] result,
  output logic [4:0]        flags_out
);

  logic [DATA_W-1:0] lhs;
  logic [DATA_W-1:0] rhs;
  logic              carry_in;
  logic [DATA_W:0]   sum;
  logic [DATA_W:0]   diff;
  logic [4:0]        half_sum;
  logic              c_out;
  logic              v_out;
  logic              h_out;

  // Inherent forms see the accumulator on both sides
  assign lhs = acc_b ? b : a;
  assign rhs = use_imm ? imm : lhs;

  assign carry_in = ((op == ALU_ADC) || (op == ALU_SBC)) & cc[CC_C];
  assign sum      = {1'b0, lhs} + {1'b0, rhs} + {{DATA_W{1'b0}}, carry_in};
  // Borrow lands in the top bit
  assign diff     = {1'b0, lhs} - {1'b0, rhs} - {{DATA_W{1'b0}}, carry_in};
  assign half_sum = {1'b0, lhs[3:0]} + {1'b0, rhs[3:0]} + {4'b0, carry_in};

  always_comb begin
    result = rhs;
    c_out  = cc[CC_C];
    v_out  = cc[CC_V];
    case (op)
      ALU_ADD, ALU_ADC: begin
        result = sum[7:0];
        c_out  = sum[8];
        v_out  = (lhs[7] == rhs[7]) && (sum[7] != lhs[7]);
      end
      ALU_SUB, ALU_SBC: begin
        result = diff[7:0];
        c_out  = diff[8];
        v_out  = (lhs[7] != rhs[7]) && (diff[7] != lhs[7]);
      end
      // --------------------
      // Logic and loads
      ALU_AND: begin
        result = lhs & rhs;
        v_out  = 1'b0;
      end
      ALU_OR: begin
        result = lhs | rhs;
        v_out  = 1'b0;
      end
      ALU_EOR: begin
        result = lhs ^ rhs;
        v_out  = 1'b0;
      end
      ALU_PASS: begin
        result = rhs;
        v_out  = 1'b0;
      end
      // --------------------
      // Single operand
      ALU_INC: begin
        result = rhs + 8'd1;
        v_out  = (rhs == 8'h7F);
      end
      ALU_DEC: begin
        result = rhs - 8'd1;
        v_out  = (rhs == 8'h80);
      end
      ALU_COM: begin
        result = ~rhs;
        v_out  = 1'b0;
        c_out  = 1'b1;
      end
      ALU_NEG: begin
        result = 8'd0 - rhs;
        v_out  = (rhs == 8'h80);
        c_out  = (rhs != 8'h00);
      end
      // Right shifts leave V alone
      ALU_ASR: begin
        result = {rhs[7], rhs[7:1]};
        c_out  = rhs[0];
      end
      ALU_LSR: begin
        result = {1'b0, rhs[7:1]};
        c_out  = rhs[0];
      end
      ALU_ROR: begin
        result = {cc[CC_C], rhs[7:1]};
        c_out  = rhs[0];
      end
      default: ;
    endcase
  end

  // Half carry only from the immediate adds
  assign h_out = (use_imm && ((op == ALU_ADD) || (op == ALU_ADC))) ? half_sum[4] : cc[CC_H];

  // Low nibble in cc order, H on top
  assign flags_out[CC_N] = result[7];
  assign flags_out[CC_Z] = (result == 8'h00);
  assign flags_out[CC_V] = v_out;
  assign flags_out[CC_C] = c_out;
  assign flags_out[4]    = h_out;

endmodule

//--- logic/cpu_core.sv
/*
  Read-only 6809-style CPU core
  Reset vector load, opcode fetch, decode, 8-bit ALU and register file,
  with a read-only view of A, B, X, U and CC
*/
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
  parameter logic [ADDR_W-1:0] RESET_VECTOR = RESET_VECTOR_DEFAULT
) (
  input  logic              clk,
  input  logic              reset_b,
  input  logic [DATA_W-1:0] din,
  output logic [ADDR_W-1:0] addr,
  output logic [DATA_W-1:0] reg_a,
  output logic [DATA_W-1:0] reg_b,
  output logic [15:0]       reg_x,
  output logic [15:0]       reg_u,
  output logic [7:0]        reg_cc
);

  // --------------------
  // Vector loader to fetcher
  logic              vector_busy;
  logic [ADDR_W-1:0] vector_addr;
  logic              vector_done;
  logic [ADDR_W-1:0] vector;

  // Fetched instruction
  opcode_u           ir;
  logic [DATA_W-1:0] pb;
  logic [DATA_W-1:0] b2;
  logic              exec;

  // Decoded controls
  alu_op_e           alu_op;
  logic              acc_b;
  logic              use_imm;
  logic              alu_en;
  logic              wr_acc;
  logic              wr_d;
  logic              wr_x;
  logic              wr_u;
  logic [15:0]       imm16;

  // ALU results
  logic [DATA_W-1:0] result;
  logic [4:0]        flags_out;

  vector_loader #(.RESET_VECTOR(RESET_VECTOR)) u_vector_loader (
    .clk(clk), .reset_b(reset_b), .din(din),
    .vector_busy(vector_busy), .vector_addr(vector_addr),
    .vector_done(vector_done), .vector(vector)
  );

  fetch_control u_fetch_control (
    .clk(clk), .reset_b(reset_b), .din(din),
    .vector_busy(vector_busy), .vector_addr(vector_addr),
    .vector_done(vector_done), .vector(vector), .cc(reg_cc),
    .addr(addr), .ir(ir), .pb(pb), .b2(b2), .exec(exec)
  );

  inst_decode u_inst_decode (
    .ir(ir), .pb(pb), .b2(b2), .exec(exec),
    .alu_op(alu_op), .acc_b(acc_b), .use_imm(use_imm), .alu_en(alu_en),
    .wr_acc(wr_acc), .wr_d(wr_d), .wr_x(wr_x), .wr_u(wr_u), .imm16(imm16)
  );

  // Immediate operand is the second instruction byte
  alu8 u_alu8 (
    .op(alu_op), .acc_b(acc_b), .use_imm(use_imm),
    .a(reg_a), .b(reg_b), .imm(pb), .cc(reg_cc),
    .result(result), .flags_out(flags_out)
  );

  reg_file u_reg_file (
    .clk(clk), .reset_b(reset_b), .alu_en(alu_en), .wr_acc(wr_acc), .acc_b(acc_b),
    .result(result), .flags_out(flags_out),
    .wr_d(wr_d), .wr_x(wr_x), .wr_u(wr_u), .imm16(imm16),
    .a(reg_a), .b(reg_b), .x(reg_x), .u(reg_u), .cc(reg_cc)
  );

endmodule

//--- logic/cpu_pkg.sv
/*
  CPU shared definitions
  Bus widths, condition code layout, opcode rows and load opcodes,
  ALU operation codes and the two-way opcode view
*/
package cpu_pkg;

  // --------------------
  // Bus widths
  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  // --------------------
  // Condition code bit positions
  localparam int CC_E = 7;
  localparam int CC_F = 6;
  localparam int CC_H = 5;
  localparam int CC_I = 4;
  localparam int CC_N = 3;
  localparam int CC_Z = 2;
  localparam int CC_V = 1;
  localparam int CC_C = 0;

  // E, F and I set out of reset, everything else clear
  localparam logic [7:0] CC_RESET = 8'((1 << CC_E) | (1 << CC_F) | (1 << CC_I));

  // Address of the vector high byte, low byte follows
  localparam logic [ADDR_W-1:0] RESET_VECTOR_DEFAULT = 16'hFFFE;

  // --------------------
  // Opcode rows (upper nibble)
  localparam logic [3:0] OPROW_BRANCH = 4'h2;
  localparam logic [3:0] OPROW_INH_A  = 4'h4;
  localparam logic [3:0] OPROW_INH_B  = 4'h5;
  localparam logic [3:0] OPROW_IMM_A  = 4'h8;
  localparam logic [3:0] OPROW_IMM_B  = 4'hC;

  // 16-bit immediate loads
  localparam logic [7:0] OP_LDD = 8'hCC;
  localparam logic [7:0] OP_LDX = 8'h8E;
  localparam logic [7:0] OP_LDU = 8'hCE;

  // ALU operations
  // ASL, ROL and CLR are ADD, ADC and SUB of the accumulator with itself
  // LD and TST share PASS, CMP runs as SUB, BIT as AND
  typedef enum logic [3:0] {
    ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
    ALU_AND, ALU_OR,  ALU_EOR, ALU_PASS,
    ALU_INC, ALU_DEC, ALU_COM, ALU_NEG,
    ALU_ASR, ALU_LSR, ALU_ROR
  } alu_op_e;

  // One opcode byte, two field layouts
  // 8x/Cx pick B with bit 6, 4x/5x pick B with bit 4
  typedef union packed {
    struct packed {
      logic       b7;
      logic       acc_b;
      logic [1:0] mode;
      logic [3:0] op;
    } imm_view;
    struct packed {
      logic [2:0] hi;
      logic       acc_b;
      logic [3:0] op;
    } inh_view;
  } opcode_u;

endpackage

//--- logic/fetch_control.sv
/*
  Instruction fetch control
  One-hot fetch FSM with opcode and operand registers, program counter,
  short branch decision and bus address mux
*/
`timescale 1ns/1ps

module fetch_control import cpu_pkg::*; (
  input  logic              clk,
  input  logic              reset_b,
  input  logic [DATA_W-1:0] din,
  input  logic              vector_busy,
  input  logic [ADDR_W-1:0] vector_addr,
  input  logic              vector_done,
  input  logic [ADDR_W-1:0] vector,
  input  logic [7:0]        cc,
  output logic [ADDR_W-1:0] addr,
  output opcode_u           ir,
  output logic [DATA_W-1:0] pb,
  output logic [DATA_W-1:0] b2,
  output logic              exec
);

  // --------------------
  // Fetch states
  localparam logic [3:0] ST_WAIT   = 4'b0001;
  localparam logic [3:0] ST_IR     = 4'b0010;
  localparam logic [3:0] ST_PB_IMM = 4'b0100;
  localparam logic [3:0] ST_B2     = 4'b1000;

  logic [3:0]        state;
  logic [3:0]        state_next;
  logic [ADDR_W-1:0] pc;
  logic [ADDR_W-1:0] pc_next;
  logic [1:0]        din_len;
  logic [1:0]        ir_len;
  logic              last_byte;
  logic              branch_cond;
  logic              take_branch;

  wire st_wait   = state[0];
  wire st_ir     = state[1];
  wire st_pb_imm = state[2];
  wire st_b2     = state[3];

  // Instruction length in bytes, unknown opcodes count as one
  function automatic logic [1:0] inst_len(input logic [7:0] op);
    logic [3:0] row;
    logic [3:0] lo;
    row = op[7:4];
    lo  = op[3:0];
    if (op == OP_LDD || op == OP_LDX || op == OP_LDU) begin
      return 2'd3;
    end
    // Kept branches, no BHI/BLS, no signed compares
    if (row == OPROW_BRANCH && lo < 4'hC && lo != 4'h2 && lo != 4'h3) begin
      return 2'd2;
    end
    // Kept immediate ops, skips the 16-bit and store slots
    if ((row == OPROW_IMM_A || row == OPROW_IMM_B) && lo < 4'hC &&
        lo != 4'h3 && lo != 4'h7) begin
      return 2'd2;
    end
    return 2'd1;
  endfunction

  // Classify the byte on the bus and the captured opcode
  assign din_len = inst_len(din);
  assign ir_len  = inst_len(ir);

  always_comb begin
    case (state)
      ST_WAIT:   state_next = vector_done ? ST_IR : ST_WAIT;
      ST_IR:     state_next = (din_len == 2'd1) ? ST_IR : ST_PB_IMM;
      ST_PB_IMM: state_next = (ir_len == 2'd3) ? ST_B2 : ST_IR;
      ST_B2:     state_next = ST_IR;
      default:   state_next = ST_WAIT;
    endcase
  end

  // Final byte of the instruction is on din
  assign last_byte = (st_ir & din_len == 2'd1) | (st_pb_imm & ir_len == 2'd2) | st_b2;

  // --------------------
  // Branch decision against the current cc
  always_comb begin
    case (ir[3:0])
      4'h0:    branch_cond = 1'b1;
      4'h4:    branch_cond = ~cc[CC_C];
      4'h5:    branch_cond = cc[CC_C];
      4'h6:    branch_cond = ~cc[CC_Z];
      4'h7:    branch_cond = cc[CC_Z];
      4'h8:    branch_cond = ~cc[CC_V];
      4'h9:    branch_cond = cc[CC_V];
      4'hA:    branch_cond = ~cc[CC_N];
      4'hB:    branch_cond = cc[CC_N];
      default: branch_cond = 1'b0;
    endcase
  end

  assign take_branch = st_pb_imm & (ir[7:4] == OPROW_BRANCH) & branch_cond;

  // pc points at the offset byte, so the target is pc + 1 + offset
  always_comb begin
    pc_next = pc + 16'd1;
    if (st_wait) begin
      pc_next = vector_done ? vector : pc;
    end else if (take_branch) begin
      pc_next = pc + 16'd1 + {{(ADDR_W-DATA_W){din[DATA_W-1]}}, din};
    end
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state <= ST_WAIT;
      pc    <= '0;
      exec  <= 1'b0;
    end else begin
      state <= state_next;
      pc    <= pc_next;
      exec  <= last_byte;
    end
  end

  // Opcode and operand capture
  always_ff @(posedge clk) begin
    if (st_ir) begin
      ir <= din;
    end
    if (st_pb_imm) begin
      pb <= din;
    end
    if (st_b2) begin
      b2 <= din;
    end
  end

  // Loader owns the bus until the vector is in
  assign addr = vector_busy ? vector_addr : pc;

endmodule

//--- logic/inst_decode.sv
/*
  Instruction decoder
  Maps the executing opcode to an ALU operation, accumulator choice
  and register write strobes
*/
`timescale 1ns/1ps

module inst_decode import cpu_pkg::*; (
  input  opcode_u           ir,
  input  logic [DATA_W-1:0] pb,
  input  logic [DATA_W-1:0] b2,
  input  logic              exec,
  output alu_op_e           alu_op,
  output logic              acc_b,
  output logic              use_imm,
  output logic              alu_en,
  output logic              wr_acc,
  output logic              wr_d,
  output logic              wr_x,
  output logic              wr_u,
  output logic [15:0]       imm16
);

  logic row_inh;
  logic row_imm;
  logic known;
  logic writes;

  assign row_inh = (ir[7:4] == OPROW_INH_A) || (ir[7:4] == OPROW_INH_B);
  assign row_imm = (ir[7:4] == OPROW_IMM_A) || (ir[7:4] == OPROW_IMM_B);

  always_comb begin
    alu_op  = ALU_PASS;
    acc_b   = 1'b0;
    use_imm = 1'b0;
    known   = 1'b0;
    writes  = 1'b1;
    if (row_inh) begin
      // --------------------
      // Inherent A/B
      acc_b = ir.inh_view.acc_b;
      known = 1'b1;
      case (ir.inh_view.op)
        4'h0:    alu_op = ALU_NEG;
        4'h3:    alu_op = ALU_COM;
        4'h4:    alu_op = ALU_LSR;
        4'h6:    alu_op = ALU_ROR;
        4'h7:    alu_op = ALU_ASR;
        4'h8:    alu_op = ALU_ADD;   // ASL, acc + acc
        4'h9:    alu_op = ALU_ADC;   // ROL, acc + acc + C
        4'hA:    alu_op = ALU_DEC;
        4'hC:    alu_op = ALU_INC;
        // TST, flags only
        4'hD: begin
          alu_op = ALU_PASS;
          writes = 1'b0;
        end
        4'hF:    alu_op = ALU_SUB;   // CLR, acc - acc
        default: known  = 1'b0;
      endcase
    end else if (row_imm) begin
      // --------------------
      // Immediate A/B
      acc_b   = ir.imm_view.acc_b;
      use_imm = 1'b1;
      known   = 1'b1;
      case (ir.imm_view.op)
        4'h0:    alu_op = ALU_SUB;
        4'h1: begin
          alu_op = ALU_SUB;
          writes = 1'b0;
        end
        4'h2:    alu_op = ALU_SBC;
        4'h4:    alu_op = ALU_AND;
        4'h5: begin
          alu_op = ALU_AND;
          writes = 1'b0;
        end
        4'h6:    alu_op = ALU_PASS;
        4'h8:    alu_op = ALU_EOR;
        4'h9:    alu_op = ALU_ADC;
        4'hA:    alu_op = ALU_OR;
        4'hB:    alu_op = ALU_ADD;
        default: known  = 1'b0;
      endcase
    end
  end

  // Strobes only in the execute cycle, unknown opcodes write nothing
  assign alu_en = exec & known;
  assign wr_acc = exec & known & writes;
  assign wr_d   = exec & (ir == OP_LDD);
  assign wr_x   = exec & (ir == OP_LDX);
  assign wr_u   = exec & (ir == OP_LDU);

  // High byte first
  assign imm16 = {pb, b2};

endmodule

//--- logic/reg_file.sv
/*
  Register file
  Holds A, B, X, U and CC, applies ALU results and 16-bit loads
*/
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
  input  logic              clk,
  input  logic              reset_b,
  input  logic              alu_en,
  input  logic              wr_acc,
  input  logic              acc_b,
  input  logic [DATA_W-1:0] result,
  input  logic [4:0]        flags_out,
  input  logic              wr_d,
  input  logic              wr_x,
  input  logic              wr_u,
  input  logic [15:0]       imm16,
  output logic [DATA_W-1:0] a,
  output logic [DATA_W-1:0] b,
  output logic [15:0]       x,
  output logic [15:0]       u,
  output logic [7:0]        cc
);

  logic [7:0] cc_next;

  // --------------------
  // Flag merge, E F I never touched
  always_comb begin
    cc_next = cc;
    if (alu_en) begin
      cc_next[CC_H] = flags_out[4];
      cc_next[CC_N] = flags_out[CC_N];
      cc_next[CC_Z] = flags_out[CC_Z];
      cc_next[CC_V] = flags_out[CC_V];
      cc_next[CC_C] = flags_out[CC_C];
    end else if (wr_d || wr_x || wr_u) begin
      // 16-bit loads keep C
      cc_next[CC_N] = imm16[15];
      cc_next[CC_Z] = (imm16 == 16'h0000);
      cc_next[CC_V] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a  <= '0;
      b  <= '0;
      x  <= '0;
      u  <= '0;
      cc <= CC_RESET;
    end else begin
      // D is A high, B low
      if (wr_acc && !acc_b) begin
        a <= result;
      end else if (wr_d) begin
        a <= imm16[15:8];
      end
      if (wr_acc && acc_b) begin
        b <= result;
      end else if (wr_d) begin
        b <= imm16[7:0];
      end
      if (wr_x) begin
        x <= imm16;
      end
      if (wr_u) begin
        u <= imm16;
      end
      cc <= cc_next;
    end
  end

endmodule

//--- logic/vector_loader.sv
/*
  Reset vector loader
  Reads the two vector bytes right after reset, then hands the
  assembled start address to the fetcher and goes idle
*/
`timescale 1ns/1ps

module vector_loader import cpu_pkg::*; #(
  parameter logic [ADDR_W-1:0] RESET_VECTOR = RESET_VECTOR_DEFAULT
) (
  input  logic              clk,
  input  logic              reset_b,
  input  logic [DATA_W-1:0] din,
  output logic              vector_busy,
  output logic [ADDR_W-1:0] vector_addr,
  output logic              vector_done,
  output logic [ADDR_W-1:0] vector
);

  // One-hot phase, both low once idle
  logic              ld_msb;
  logic              ld_lsb;
  logic [DATA_W-1:0] msb_q;

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      ld_msb <= 1'b1;
      ld_lsb <= 1'b0;
    end else begin
      ld_msb <= 1'b0;
      ld_lsb <= ld_msb;
    end
  end

  // Stage the high byte
  always_ff @(posedge clk) begin
    if (ld_msb) begin
      msb_q <= din;
    end
  end

  assign vector_busy = ld_msb | ld_lsb;
  assign vector_addr = ld_msb ? RESET_VECTOR : RESET_VECTOR + 16'd1;
  // Low byte comes straight off the bus
  assign vector_done = ld_lsb;
  assign vector      = {msb_q, din};

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CPU core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_cpu_core -o sim_cpu_core

# Keep running past assertion errors so the testbench prints its verdict
out=$(./obj_dir/sim_cpu_core +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
  exit 0
else
  exit 1
fi

//--- testbench/cpu_core_chk.sv
/*
  Bus and condition code checks for the CPU core
  Bound into the core, watches the reset sequence, the address step,
  the fixed E F I bits and unknowns on the address bus
*/
`timescale 1ns/1ps

module cpu_core_chk import cpu_pkg::*; #(
  parameter logic [ADDR_W-1:0] RESET_VECTOR = RESET_VECTOR_DEFAULT
) (
  input logic              clk,
  input logic              reset_b,
  input logic [DATA_W-1:0] din,
  input logic [ADDR_W-1:0] addr,
  input logic [7:0]        ir,
  input logic [7:0]        reg_cc
);

  // Cycles since reset, saturates at 3
  logic [1:0] phase;
  int         fail_count = 0;

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      phase <= 2'd0;
    end else if (phase != 2'd3) begin
      phase <= phase + 2'd1;
    end
  end

  // --------------------
  // Reset vector reads, then the first opcode
  a_vec_hi: assert property (@(posedge clk) disable iff (!reset_b)
    phase == 2'd0 |-> addr == RESET_VECTOR)
    else begin
      fail_count++;
      $error("first address after reset is not the vector high byte");
    end

  a_vec_lo: assert property (@(posedge clk) disable iff (!reset_b)
    phase == 2'd1 |-> addr == RESET_VECTOR + 16'd1)
    else begin
      fail_count++;
      $error("second address after reset is not the vector low byte");
    end

  a_start: assert property (@(posedge clk) disable iff (!reset_b)
    phase == 2'd2 |-> addr == {$past(din, 2), $past(din)})
    else begin
      fail_count++;
      $error("first opcode fetch is not at the vector address");
    end

  // Plus one per cycle, or a jump after a branch offset byte
  a_step: assert property (@(posedge clk) disable iff (!reset_b)
    phase == 2'd3 |-> (addr == $past(addr) + 16'd1) ||
      ($past(ir[7:4]) == OPROW_BRANCH &&
       addr == $past(addr) + 16'd1 + {{8{$past(din[7])}}, $past(din)}))
    else begin
      fail_count++;
      $error("address did not follow the one read per cycle rule");
    end

  a_efi: assert property (@(posedge clk) disable iff (!reset_b)
    reg_cc[CC_E] && reg_cc[CC_F] && reg_cc[CC_I])
    else begin
      fail_count++;
      $error("E, F or I changed in the condition codes");
    end

  a_known: assert property (@(posedge clk) disable iff (!reset_b)
    !$isunknown(addr))
    else begin
      fail_count++;
      $error("address bus has unknown bits");
    end

endmodule

bind cpu_core cpu_core_chk #(.RESET_VECTOR(RESET_VECTOR)) u_chk (
  .clk(clk), .reset_b(reset_b), .din(din), .addr(addr), .ir(ir), .reg_cc(reg_cc)
);

//--- testbench/tb_cpu_core.sv
/*
  CPU core testbench
  Memory model, random program from the kept opcodes, instruction-level
  model with per-cycle address and register view checks, watchdog
*/
`timescale 1ns/1ps

module tb_cpu_core import cpu_pkg::*;;

  localparam logic [15:0] RESET_VEC = RESET_VECTOR_DEFAULT;
  localparam int          N_INST    = 120;

  logic        clk;
  logic        reset_b;
  logic [7:0]  din;
  logic [15:0] addr;
  logic [7:0]  reg_a;
  logic [7:0]  reg_b;
  logic [15:0] reg_x;
  logic [15:0] reg_u;
  logic [7:0]  reg_cc;

  logic [7:0]  mem [0:65535];
  logic [7:0]  op_tab [$];
  int          len_tab [$];
  // Expected fetch address per fetch cycle, and model state
  // before the instruction that owns that fetch
  logic [15:0] fa [0:1023];
  logic [7:0]  va [0:1023];
  logic [7:0]  vb [0:1023];
  logic [15:0] vx [0:1023];
  logic [15:0] vu [0:1023];
  logic [7:0]  vcc [0:1023];
  // Model registers
  logic [7:0]  m_a;
  logic [7:0]  m_b;
  logic [15:0] m_x;
  logic [15:0] m_u;
  logic [7:0]  m_cc;
  integer      seed;
  int          nf;
  int          checks;
  int          errors;
  logic        prog_ready;
  logic        run_done;

  cpu_core #(.RESET_VECTOR(RESET_VEC)) uut (
    .clk(clk), .reset_b(reset_b), .din(din), .addr(addr),
    .reg_a(reg_a), .reg_b(reg_b), .reg_x(reg_x), .reg_u(reg_u), .reg_cc(reg_cc)
  );

  // Combinational read, same cycle
  assign din = mem[addr];

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic add_op(input logic [7:0] op, input int len);
    op_tab.push_back(op);
    len_tab.push_back(len);
  endtask

  // --------------------
  // Kept opcodes with lengths, plus a few dropped ones as no-ops
  task automatic build_table();
    logic [3:0] inh_lo [11] = '{4'h0, 4'h3, 4'h4, 4'h6, 4'h7, 4'h8, 4'h9, 4'hA,
                                4'hC, 4'hD, 4'hF};
    logic [3:0] imm_lo [10] = '{4'h0, 4'h1, 4'h2, 4'h4, 4'h5, 4'h6, 4'h8, 4'h9,
                                4'hA, 4'hB};
    logic [3:0] br_lo [10] = '{4'h0, 4'h1, 4'h4, 4'h5, 4'h6, 4'h7, 4'h8, 4'h9,
                               4'hA, 4'hB};
    foreach (inh_lo[i]) begin
      add_op({4'h4, inh_lo[i]}, 1);
      add_op({4'h5, inh_lo[i]}, 1);
    end
    foreach (imm_lo[i]) begin
      add_op({4'h8, imm_lo[i]}, 2);
      add_op({4'hC, imm_lo[i]}, 2);
    end
    foreach (br_lo[i]) begin
      add_op({4'h2, br_lo[i]}, 2);
    end
    add_op(8'hCC, 3);
    add_op(8'h8E, 3);
    add_op(8'hCE, 3);
    add_op(8'h12, 1);
    add_op(8'h4E, 1);
    add_op(8'h9B, 1);
  endtask

  function automatic logic branch_taken(input logic [3:0] lo, input logic [7:0] cc);
    case (lo)
      4'h0:    return 1'b1;
      4'h4:    return !cc[CC_C];
      4'h5:    return cc[CC_C];
      4'h6:    return !cc[CC_Z];
      4'h7:    return cc[CC_Z];
      4'h8:    return !cc[CC_V];
      4'h9:    return cc[CC_V];
      4'hA:    return !cc[CC_N];
      4'hB:    return cc[CC_N];
      default: return 1'b0;
    endcase
  endfunction

  // --------------------
  // 6809 semantics for the kept non-branch opcodes
  task automatic model_exec(input logic [7:0] op, input logic [7:0] p, input logic [7:0] q);
    logic [7:0] acc;
    logic [7:0] res;
    logic [8:0] w;
    logic [4:0] hs;
    logic       cin;
    logic       v;
    logic       c;
    logic       h;
    logic       flags;
    logic       wr;
    acc   = (op[7:4] == 4'h5 || op[7:4] == 4'hC) ? m_b : m_a;
    res   = acc;
    v     = m_cc[CC_V];
    c     = m_cc[CC_C];
    h     = m_cc[CC_H];
    flags = 1'b1;
    wr    = 1'b1;
    if (op == 8'hCC || op == 8'h8E || op == 8'hCE) begin
      if (op == 8'hCC) begin
        m_a = p;
        m_b = q;
      end else if (op == 8'h8E) begin
        m_x = {p, q};
      end else begin
        m_u = {p, q};
      end
      m_cc[CC_N] = p[7];
      m_cc[CC_Z] = ({p, q} == 16'h0000);
      m_cc[CC_V] = 1'b0;
      return;
    end else if (op[7:4] == 4'h4 || op[7:4] == 4'h5) begin
      case (op[3:0])
        4'h0: begin
          res = 8'h00 - acc;
          v   = (acc == 8'h80);
          c   = (acc != 8'h00);
        end
        4'h3: begin
          res = ~acc;
          v   = 1'b0;
          c   = 1'b1;
        end
        4'h4: begin
          res = {1'b0, acc[7:1]};
          c   = acc[0];
        end
        4'h6: begin
          res = {m_cc[CC_C], acc[7:1]};
          c   = acc[0];
        end
        4'h7: begin
          res = {acc[7], acc[7:1]};
          c   = acc[0];
        end
        4'h8: begin
          res = {acc[6:0], 1'b0};
          c   = acc[7];
          v   = acc[7] ^ acc[6];
        end
        4'h9: begin
          res = {acc[6:0], m_cc[CC_C]};
          c   = acc[7];
          v   = acc[7] ^ acc[6];
        end
        4'hA: begin
          res = acc - 8'd1;
          v   = (acc == 8'h80);
        end
        4'hC: begin
          res = acc + 8'd1;
          v   = (acc == 8'h7F);
        end
        4'hD: begin
          v  = 1'b0;
          wr = 1'b0;
        end
        4'hF: begin
          res = 8'h00;
          v   = 1'b0;
          c   = 1'b0;
        end
        default: begin
          flags = 1'b0;
          wr    = 1'b0;
        end
      endcase
    end else if (op[7:4] == 4'h8 || op[7:4] == 4'hC) begin
      case (op[3:0])
        // SUB, CMP, SBC
        4'h0, 4'h1, 4'h2: begin
          cin = (op[3:0] == 4'h2) & m_cc[CC_C];
          w   = {1'b0, acc} - {1'b0, p} - {8'h00, cin};
          res = w[7:0];
          c   = w[8];
          v   = (acc[7] != p[7]) && (res[7] != acc[7]);
          wr  = (op[3:0] != 4'h1);
        end
        4'h4, 4'h5: begin
          res = acc & p;
          v   = 1'b0;
          wr  = (op[3:0] == 4'h4);
        end
        4'h6: begin
          res = p;
          v   = 1'b0;
        end
        4'h8: begin
          res = acc ^ p;
          v   = 1'b0;
        end
        4'hA: begin
          res = acc | p;
          v   = 1'b0;
        end
        // ADC, ADD
        4'h9, 4'hB: begin
          cin = (op[3:0] == 4'h9) & m_cc[CC_C];
          w   = {1'b0, acc} + {1'b0, p} + {8'h00, cin};
          hs  = {1'b0, acc[3:0]} + {1'b0, p[3:0]} + {4'h0, cin};
          res = w[7:0];
          c   = w[8];
          h   = hs[4];
          v   = (acc[7] == p[7]) && (res[7] != acc[7]);
        end
        default: begin
          flags = 1'b0;
          wr    = 1'b0;
        end
      endcase
    end else begin
      flags = 1'b0;
      wr    = 1'b0;
    end
    if (flags) begin
      m_cc[CC_H] = h;
      m_cc[CC_N] = res[7];
      m_cc[CC_Z] = (res == 8'h00);
      m_cc[CC_V] = v;
      m_cc[CC_C] = c;
    end
    if (wr && (op[7:4] == 4'h5 || op[7:4] == 4'hC)) begin
      m_b = res;
    end else if (wr) begin
      m_a = res;
    end
  endtask

  // Writes the program forward only, predicting fetches and views
  task automatic build_program();
    logic [15:0] pc;
    logic [31:0] rnd;
    logic [7:0]  op;
    logic [7:0]  p;
    logic [7:0]  q;
    int          k;
    int          len;
    pc = 16'h0100;
    nf = 0;
    for (int i = 0; i < N_INST; i++) begin
      rnd = $random(seed);
      k   = int'(rnd[15:0]) % op_tab.size();
      op  = op_tab[k];
      len = len_tab[k];
      rnd = $random(seed);
      p   = rnd[7:0];
      q   = rnd[15:8];
      // Short forward offsets keep the path inside the program
      if (op[7:4] == 4'h2) begin
        p = {4'h0, rnd[3:0]};
      end
      for (int j = 0; j < len; j++) begin
        mem[pc + 16'(j)] = (j == 0) ? op : ((j == 1) ? p : q);
        fa[nf + j]  = pc + 16'(j);
        va[nf + j]  = m_a;
        vb[nf + j]  = m_b;
        vx[nf + j]  = m_x;
        vu[nf + j]  = m_u;
        vcc[nf + j] = m_cc;
      end
      nf = nf + len;
      if (op[7:4] == 4'h2 && len == 2) begin
        pc = branch_taken(op[3:0], m_cc) ? pc + 16'd2 + {8'h00, p} : pc + 16'd2;
      end else begin
        model_exec(op, p, q);
        pc = pc + 16'(len);
      end
    end
    va[nf]  = m_a;
    vb[nf]  = m_b;
    vx[nf]  = m_x;
    vu[nf]  = m_u;
    vcc[nf] = m_cc;
  endtask

  task automatic compare(input string name, input logic [15:0] expv, input logic [15:0] actv);
    checks++;
    assert (actv === expv) else begin
      errors++;
      $display("Error: time %0t %s expected %h got %h", $time, name, expv, actv);
    end
  endtask

  task automatic check_view(input int f);
    compare("reg_a", {8'h00, va[f]}, {8'h00, reg_a});
    compare("reg_b", {8'h00, vb[f]}, {8'h00, reg_b});
    compare("reg_x", vx[f], reg_x);
    compare("reg_u", vu[f], reg_u);
    compare("reg_cc", {8'h00, vcc[f]}, {8'h00, reg_cc});
  endtask

  // --------------------
  // Stimulus and per-cycle checks, sampled mid-cycle
  initial begin
    reset_b    = 1'b0;
    seed       = 32'he514_169a;
    checks     = 0;
    errors     = 0;
    prog_ready = 1'b0;
    run_done   = 1'b0;
    m_a        = 8'h00;
    m_b        = 8'h00;
    m_x        = 16'h0000;
    m_u        = 16'h0000;
    m_cc       = CC_RESET;
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 8'(i >> 8) ^ 8'(i) ^ 8'h5A;
    end
    // Start address 0x0100
    mem[RESET_VEC]         = 8'h01;
    mem[RESET_VEC + 16'd1] = 8'h00;
    build_table();
    build_program();
    prog_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1 reset_b = 1'b1;
    for (int cyc = 0; cyc <= nf + 3; cyc++) begin
      @(negedge clk);
      if (cyc < 2) begin
        compare("addr", RESET_VEC + 16'(cyc), addr);
      end else if (cyc - 2 < nf) begin
        compare("addr", fa[cyc - 2], addr);
      end
      // View trails the fetch by the execute cycle
      check_view((cyc < 3) ? 0 : cyc - 3);
    end
    run_done = 1'b1;
    $display("Checks %0d, value errors %0d, assertion failures %0d",
             checks, errors, uut.u_chk.fail_count);
    if (errors == 0 && uut.u_chk.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog, twice the predicted cycles plus reset
  initial begin
    wait (prog_ready);
    #((2 * (nf + 4) + 8) * 4);
    if (!run_done) begin
      $display("Timeout: the program did not complete in the expected number of cycles");
      $display("=== FAIL ===");
      $finish;
    end
  end

endmodule
